/* include/cpu_params.svh */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

`define XLEN        32
`define REG_ADDR_W  5
`define NUM_REGS    32
`define WMASK_W     4
`define RESET_PC    32'h1c00_0000

// one-hot alu operation, bit positions
`define ALU_OP_W    6
`define ALU_ADD     0
`define ALU_SUB     1
`define ALU_AND     2
`define ALU_OR      3
`define ALU_XOR     4
`define ALU_LUI     5

// register alu ops match inst[31:15]
`define OP_ADD_W    17'h00020
`define OP_SUB_W    17'h00022
`define OP_AND      17'h00029
`define OP_OR       17'h0002a
`define OP_XOR      17'h0002b
// si12 formats match inst[31:22]
`define OP_ADDI_W   10'h00a
`define OP_LD_W     10'h0a2
`define OP_ST_W     10'h0a6
`define OP_LU12I_W  7'h0a       // inst[31:25]
// branches match inst[31:26]
`define OP_B        6'h14
`define OP_BEQ      6'h16
`define OP_BNE      6'h17

`endif

/* logic/cpu_pkg.sv */
`include "cpu_params.svh"

package cpu_pkg;

    // data word, address or pc
    typedef logic [`XLEN-1:0] word_t;

    // raw instruction
    typedef logic [31:0] inst_t;

    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // sram byte enables
    typedef logic [`WMASK_W-1:0] wmask_t;

    // one-hot, see ALU_* positions
    typedef logic [`ALU_OP_W-1:0] alu_op_t;

endpackage

/* logic/pipe_buses.sv */
// fetch to decode
interface fetch_bus;
    import cpu_pkg::*;

    logic  valid;
    logic  allowin;
    word_t pc;
    inst_t inst;            // straight from the instruction sram

    modport src  (output valid, pc, inst, input allowin);
    modport sink (input valid, pc, inst, output allowin);
endinterface

// decode to execute
interface decode_bus;
    import cpu_pkg::*;

    logic      valid;
    logic      allowin;
    word_t     pc;
    alu_op_t   alu_op;
    word_t     src1;
    word_t     src2;
    logic      rf_we;
    reg_addr_t dest;
    logic      res_from_mem;
    logic      mem_we;
    word_t     store_data;

    modport src  (output valid, pc, alu_op, src1, src2, rf_we, dest,
                  res_from_mem, mem_we, store_data, input allowin);
    modport sink (input valid, pc, alu_op, src1, src2, rf_we, dest,
                  res_from_mem, mem_we, store_data, output allowin);
endinterface

// execute to memory/writeback
interface exec_bus;
    import cpu_pkg::*;

    logic      valid;
    logic      allowin;
    word_t     pc;
    word_t     alu_result;
    logic      rf_we;
    reg_addr_t dest;
    logic      res_from_mem;

    modport src  (output valid, pc, alu_result, rf_we, dest, res_from_mem, input allowin);
    modport sink (input valid, pc, alu_result, rf_we, dest, res_from_mem, output allowin);
endinterface

/* logic/stage_fetch.sv */
`include "cpu_params.svh"

module stage_fetch (
    input  logic           clk,
    input  logic           reset,
    input  logic           br_taken,
    input  cpu_pkg::word_t br_target,
    input  cpu_pkg::word_t inst_sram_rdata,
    output logic           inst_sram_en,
    output cpu_pkg::word_t inst_sram_addr,
    fetch_bus.src          fb
);
    import cpu_pkg::*;

    logic  pf_valid;
    word_t pf_pc;
    word_t next_pc;
    logic  fetch_go;
    logic  fs_valid;
    logic  fs_allowin;
    word_t fs_pc;

    // pre-fetch comes up one cycle after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            pf_valid <= 1'b0;
        end else begin
            pf_valid <= 1'b1;
        end
    end

    assign next_pc  = br_taken ? br_target : pf_pc + 32'd4;
    assign fetch_go = pf_valid && fs_allowin;

    // one word below so the first next_pc is the reset vector
    always_ff @(posedge clk) begin
        if (reset) begin
            pf_pc <= `RESET_PC - 32'd4;
        end else if (fetch_go) begin
            pf_pc <= next_pc;
        end
    end

    assign inst_sram_en   = fetch_go;   // low while decode holds us
    assign inst_sram_addr = next_pc;

    assign fs_allowin = !fs_valid || fb.allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            fs_valid <= 1'b0;
        end else if (fs_allowin) begin
            fs_valid <= pf_valid;
        end else if (br_taken) begin
            fs_valid <= 1'b0;           // stuck wrong-path fetch
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_go) begin
            fs_pc <= next_pc;
        end
    end

    assign fb.valid = fs_valid;
    assign fb.pc    = fs_pc;
    assign fb.inst  = inst_sram_rdata;  // sram holds it while en is low

endmodule

/* logic/stage_decode.sv */
`include "cpu_params.svh"

module stage_decode (
    input  logic               clk,
    input  logic               reset,
    input  cpu_pkg::word_t     rf_rdata1,
    input  cpu_pkg::word_t     rf_rdata2,
    input  cpu_pkg::reg_addr_t ex_busy_reg,
    input  cpu_pkg::reg_addr_t mem_busy_reg,
    input  cpu_pkg::reg_addr_t wb_busy_reg,
    output cpu_pkg::reg_addr_t rf_raddr1,
    output cpu_pkg::reg_addr_t rf_raddr2,
    output logic               br_taken,
    output cpu_pkg::word_t     br_target,
    fetch_bus.sink             fb,
    decode_bus.src             db
);
    import cpu_pkg::*;

    logic      ds_valid;
    word_t     ds_pc;
    inst_t     ds_inst;
    logic      ready_go;
    logic      stall;
    logic      hit1;
    logic      hit2;
    reg_addr_t rd;
    reg_addr_t rj;
    reg_addr_t rk;
    logic      inst_add_w, inst_sub_w, inst_and, inst_or, inst_xor;
    logic      inst_addi_w, inst_lu12i_w, inst_ld_w, inst_st_w;
    logic      inst_b, inst_beq, inst_bne;
    logic      reg_alu;
    logic      src2_is_imm;
    logic      gr_we;
    logic      rj_eq_rd;
    word_t     imm;
    word_t     br_offs;
    alu_op_t   alu_op;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (br_taken) begin
            ds_valid <= 1'b0;           // drops the younger fetched inst
        end else if (fb.allowin) begin
            ds_valid <= fb.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fb.valid && fb.allowin) begin
            ds_pc   <= fb.pc;
            ds_inst <= fb.inst;
        end
    end

    assign rd = ds_inst[4:0];
    assign rj = ds_inst[9:5];
    assign rk = ds_inst[14:10];

    assign inst_add_w   = ds_inst[31:15] == `OP_ADD_W;
    assign inst_sub_w   = ds_inst[31:15] == `OP_SUB_W;
    assign inst_and     = ds_inst[31:15] == `OP_AND;
    assign inst_or      = ds_inst[31:15] == `OP_OR;
    assign inst_xor     = ds_inst[31:15] == `OP_XOR;
    assign inst_addi_w  = ds_inst[31:22] == `OP_ADDI_W;
    assign inst_ld_w    = ds_inst[31:22] == `OP_LD_W;
    assign inst_st_w    = ds_inst[31:22] == `OP_ST_W;
    assign inst_lu12i_w = ds_inst[31:25] == `OP_LU12I_W;
    assign inst_b       = ds_inst[31:26] == `OP_B;
    assign inst_beq     = ds_inst[31:26] == `OP_BEQ;
    assign inst_bne     = ds_inst[31:26] == `OP_BNE;

    assign reg_alu = inst_add_w | inst_sub_w | inst_and | inst_or | inst_xor;

    assign alu_op[`ALU_ADD] = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w;
    assign alu_op[`ALU_SUB] = inst_sub_w;
    assign alu_op[`ALU_AND] = inst_and;
    assign alu_op[`ALU_OR]  = inst_or;
    assign alu_op[`ALU_XOR] = inst_xor;
    assign alu_op[`ALU_LUI] = inst_lu12i_w;

    // si20 for lu12i, si12 otherwise
    assign imm = inst_lu12i_w ? {ds_inst[24:5], 12'b0}
                              : {{20{ds_inst[21]}}, ds_inst[21:10]};

    // offs26 for b, offs16 for beq/bne
    assign br_offs = inst_b ? {{4{ds_inst[9]}}, ds_inst[9:0], ds_inst[25:10], 2'b0}
                            : {{14{ds_inst[25]}}, ds_inst[25:10], 2'b0};

    assign src2_is_imm = inst_addi_w | inst_ld_w | inst_st_w | inst_lu12i_w;
    assign gr_we       = reg_alu | inst_addi_w | inst_lu12i_w | inst_ld_w;

    // unused ports read r0 so they never interlock
    assign rf_raddr1 = (inst_b | inst_lu12i_w) ? '0 : rj;
    assign rf_raddr2 = (inst_beq | inst_bne | inst_st_w) ? rd :
                       reg_alu                           ? rk : '0;

    assign hit1 = (rf_raddr1 != '0) && (rf_raddr1 == ex_busy_reg ||
                                        rf_raddr1 == mem_busy_reg ||
                                        rf_raddr1 == wb_busy_reg);
    assign hit2 = (rf_raddr2 != '0) && (rf_raddr2 == ex_busy_reg ||
                                        rf_raddr2 == mem_busy_reg ||
                                        rf_raddr2 == wb_busy_reg);
    assign stall    = hit1 || hit2;     // wait for writer to leave wb
    assign ready_go = ds_valid && !stall;

    assign rj_eq_rd  = rf_rdata1 == rf_rdata2;
    assign br_taken  = ready_go && (inst_b || (inst_beq && rj_eq_rd) ||
                                    (inst_bne && !rj_eq_rd));
    assign br_target = ds_pc + br_offs;

    assign fb.allowin = !ds_valid || (ready_go && db.allowin);

    assign db.valid        = ready_go;
    assign db.pc           = ds_pc;
    assign db.alu_op       = alu_op;
    assign db.src1         = rf_rdata1;
    assign db.src2         = src2_is_imm ? imm : rf_rdata2;
    assign db.rf_we        = gr_we;
    assign db.dest         = rd;
    assign db.res_from_mem = inst_ld_w;
    assign db.mem_we       = inst_st_w;
    assign db.store_data   = rf_rdata2;

    // taken branch always squashes the slot behind it
    a_br_squash: assert property (@(posedge clk) disable iff (reset)
        br_taken |-> ds_valid ##1 !ds_valid);

endmodule

/* logic/regfile.sv */
`include "cpu_params.svh"

module regfile (
    input  logic               clk,
    input  cpu_pkg::reg_addr_t raddr1,
    input  cpu_pkg::reg_addr_t raddr2,
    output cpu_pkg::word_t     rdata1,
    output cpu_pkg::word_t     rdata2,
    input  logic               we,
    input  cpu_pkg::reg_addr_t waddr,
    input  cpu_pkg::word_t     wdata
);
    import cpu_pkg::*;

    word_t regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 never stored
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    a_r0_zero: assert property (@(posedge clk)
        (raddr1 == '0) |-> (rdata1 == '0));

endmodule

/* logic/stage_execute.sv */
`include "cpu_params.svh"

module stage_execute (
    input  logic               clk,
    input  logic               reset,
    output logic               data_sram_en,
    output cpu_pkg::wmask_t    data_sram_we,
    output cpu_pkg::word_t     data_sram_addr,
    output cpu_pkg::word_t     data_sram_wdata,
    output cpu_pkg::reg_addr_t ex_busy_reg,
    decode_bus.sink            db,
    exec_bus.src               xb
);
    import cpu_pkg::*;

    logic      es_valid;
    logic      es_allowin;
    word_t     es_pc;
    alu_op_t   es_alu_op;
    word_t     es_src1;
    word_t     es_src2;
    logic      es_rf_we;
    reg_addr_t es_dest;
    logic      es_res_from_mem;
    logic      es_mem_we;
    word_t     es_store_data;
    word_t     add_res;
    word_t     sub_res;
    word_t     alu_result;

    assign es_allowin = !es_valid || xb.allowin;
    assign db.allowin = es_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= db.valid;       // bubble when decode stalls
        end
    end

    always_ff @(posedge clk) begin
        if (db.valid && es_allowin) begin
            es_pc           <= db.pc;
            es_alu_op       <= db.alu_op;
            es_src1         <= db.src1;
            es_src2         <= db.src2;
            es_rf_we        <= db.rf_we;
            es_dest         <= db.dest;
            es_res_from_mem <= db.res_from_mem;
            es_mem_we       <= db.mem_we;
            es_store_data   <= db.store_data;
        end
    end

    assign add_res = es_src1 + es_src2;
    assign sub_res = es_src1 - es_src2;

    // and-or mux over the one-hot op
    assign alu_result = ({`XLEN{es_alu_op[`ALU_ADD]}} & add_res)
                      | ({`XLEN{es_alu_op[`ALU_SUB]}} & sub_res)
                      | ({`XLEN{es_alu_op[`ALU_AND]}} & (es_src1 & es_src2))
                      | ({`XLEN{es_alu_op[`ALU_OR]}}  & (es_src1 | es_src2))
                      | ({`XLEN{es_alu_op[`ALU_XOR]}} & (es_src1 ^ es_src2))
                      | ({`XLEN{es_alu_op[`ALU_LUI]}} & es_src2);

    assign data_sram_en    = es_valid;  // read issued for every inst
    assign data_sram_we    = {`WMASK_W{es_valid && es_mem_we}};
    assign data_sram_addr  = alu_result;
    assign data_sram_wdata = es_store_data;

    assign ex_busy_reg = (es_valid && es_rf_we) ? es_dest : '0;

    assign xb.valid        = es_valid;
    assign xb.pc           = es_pc;
    assign xb.alu_result   = alu_result;
    assign xb.rf_we        = es_rf_we;
    assign xb.dest         = es_dest;
    assign xb.res_from_mem = es_res_from_mem;

    // decoder must hand over a single operation
    a_alu_onehot: assert property (@(posedge clk) disable iff (reset)
        es_valid |-> $onehot0(es_alu_op));

endmodule

/* logic/stage_mem_wb.sv */
`include "cpu_params.svh"

module stage_mem_wb (
    input  logic               clk,
    input  logic               reset,
    input  cpu_pkg::word_t     data_sram_rdata,
    output logic               rf_we,
    output cpu_pkg::reg_addr_t rf_waddr,
    output cpu_pkg::word_t     rf_wdata,
    output cpu_pkg::reg_addr_t mem_busy_reg,
    output cpu_pkg::reg_addr_t wb_busy_reg,
    output cpu_pkg::word_t     debug_wb_pc,
    output cpu_pkg::wmask_t    debug_wb_rf_we,
    output cpu_pkg::reg_addr_t debug_wb_rf_wnum,
    output cpu_pkg::word_t     debug_wb_rf_wdata,
    exec_bus.sink              xb
);
    import cpu_pkg::*;

    logic      ms_valid;
    word_t     ms_pc;
    word_t     ms_alu_result;
    logic      ms_rf_we;
    reg_addr_t ms_dest;
    logic      ms_res_from_mem;
    word_t     ms_result;
    logic      ws_valid;
    word_t     ws_pc;
    logic      ws_rf_we;
    reg_addr_t ws_dest;
    word_t     ws_wdata;

    assign xb.allowin = 1'b1;           // writeback never stalls

    always_ff @(posedge clk) begin
        if (reset) begin
            ms_valid <= 1'b0;
            ws_valid <= 1'b0;
        end else begin
            ms_valid <= xb.valid;
            ws_valid <= ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (xb.valid) begin
            ms_pc           <= xb.pc;
            ms_alu_result   <= xb.alu_result;
            ms_rf_we        <= xb.rf_we;
            ms_dest         <= xb.dest;
            ms_res_from_mem <= xb.res_from_mem;
        end
    end

    // load data arrives one cycle after the execute request
    assign ms_result = ms_res_from_mem ? data_sram_rdata : ms_alu_result;

    always_ff @(posedge clk) begin
        if (ms_valid) begin
            ws_pc    <= ms_pc;
            ws_rf_we <= ms_rf_we;
            ws_dest  <= ms_dest;
            ws_wdata <= ms_result;
        end
    end

    assign mem_busy_reg = (ms_valid && ms_rf_we) ? ms_dest : '0;
    assign wb_busy_reg  = (ws_valid && ws_rf_we) ? ws_dest : '0;

    assign rf_we    = ws_valid && ws_rf_we;
    assign rf_waddr = ws_dest;
    assign rf_wdata = ws_wdata;

    assign debug_wb_pc       = ws_pc;
    assign debug_wb_rf_we    = {`WMASK_W{rf_we}};
    assign debug_wb_rf_wnum  = ws_dest;
    assign debug_wb_rf_wdata = ws_wdata;

    // one cycle after a reset edge the trace must be quiet
    a_trace_reset: assert property (@(posedge clk)
        $past(reset) |-> debug_wb_rf_we == '0);

endmodule

/* logic/cpu_top.sv */
module cpu_top (
    input  logic               clk,
    input  logic               reset,
    output logic               inst_sram_en,
    output cpu_pkg::word_t     inst_sram_addr,
    input  cpu_pkg::word_t     inst_sram_rdata,
    output logic               data_sram_en,
    output cpu_pkg::wmask_t    data_sram_we,
    output cpu_pkg::word_t     data_sram_addr,
    output cpu_pkg::word_t     data_sram_wdata,
    input  cpu_pkg::word_t     data_sram_rdata,
    output cpu_pkg::word_t     debug_wb_pc,
    output cpu_pkg::wmask_t    debug_wb_rf_we,
    output cpu_pkg::reg_addr_t debug_wb_rf_wnum,
    output cpu_pkg::word_t     debug_wb_rf_wdata
);
    import cpu_pkg::*;

    logic      br_taken;
    word_t     br_target;
    reg_addr_t ex_busy_reg;
    reg_addr_t mem_busy_reg;
    reg_addr_t wb_busy_reg;
    reg_addr_t rf_raddr1;
    reg_addr_t rf_raddr2;
    word_t     rf_rdata1;
    word_t     rf_rdata2;
    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     rf_wdata;

    fetch_bus  f_bus ();
    decode_bus d_bus ();
    exec_bus   x_bus ();

    stage_fetch u_fetch (
        .clk(clk), .reset(reset),
        .br_taken(br_taken), .br_target(br_target),
        .inst_sram_rdata(inst_sram_rdata),
        .inst_sram_en(inst_sram_en), .inst_sram_addr(inst_sram_addr),
        .fb(f_bus.src)
    );

    stage_decode u_decode (
        .clk(clk), .reset(reset),
        .rf_rdata1(rf_rdata1), .rf_rdata2(rf_rdata2),
        .ex_busy_reg(ex_busy_reg), .mem_busy_reg(mem_busy_reg), .wb_busy_reg(wb_busy_reg),
        .rf_raddr1(rf_raddr1), .rf_raddr2(rf_raddr2),
        .br_taken(br_taken), .br_target(br_target),
        .fb(f_bus.sink), .db(d_bus.src)
    );

    regfile u_regfile (
        .clk(clk),
        .raddr1(rf_raddr1), .raddr2(rf_raddr2),
        .rdata1(rf_rdata1), .rdata2(rf_rdata2),
        .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata)
    );

    stage_execute u_execute (
        .clk(clk), .reset(reset),
        .data_sram_en(data_sram_en), .data_sram_we(data_sram_we),
        .data_sram_addr(data_sram_addr), .data_sram_wdata(data_sram_wdata),
        .ex_busy_reg(ex_busy_reg),
        .db(d_bus.sink), .xb(x_bus.src)
    );

    stage_mem_wb u_mem_wb (
        .clk(clk), .reset(reset),
        .data_sram_rdata(data_sram_rdata),
        .rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
        .mem_busy_reg(mem_busy_reg), .wb_busy_reg(wb_busy_reg),
        .debug_wb_pc(debug_wb_pc), .debug_wb_rf_we(debug_wb_rf_we),
        .debug_wb_rf_wnum(debug_wb_rf_wnum), .debug_wb_rf_wdata(debug_wb_rf_wdata),
        .xb(x_bus.sink)
    );

endmodule

/* tests/sram_model.sv */
`include "cpu_params.svh"

module sram_model (
    input  logic            clk,
    input  logic            inst_en,
    input  cpu_pkg::word_t  inst_addr,
    output cpu_pkg::word_t  inst_rdata,
    input  logic            data_en,
    input  cpu_pkg::wmask_t data_we,
    input  cpu_pkg::word_t  data_addr,
    input  cpu_pkg::word_t  data_wdata,
    output cpu_pkg::word_t  data_rdata
);
    timeunit 1ns;
    timeprecision 1ps;
    import cpu_pkg::*;

    word_t inst_mem [1024];         // 4 KiB, aliased by addr[11:2]
    word_t data_mem [1024];

    initial begin
        inst_rdata = '0;
        data_rdata = '0;
        fill_inst();
        for (int i = 0; i < 1024; i++) begin
            data_mem[i] = 32'hd000_0000 | word_t'(i << 2);  // tag plus byte address
        end
    end

    // read data stays put while en is low
    always @(posedge clk) begin
        if (inst_en) begin
            inst_rdata <= inst_mem[inst_addr[11:2]];
        end
    end

    always @(posedge clk) begin
        if (data_en) begin
            data_rdata <= data_mem[data_addr[11:2]];
            for (int b = 0; b < `WMASK_W; b++) begin
                if (data_we[b]) begin
                    data_mem[data_addr[11:2]][8*b +: 8] <= data_wdata[8*b +: 8];
                end
            end
        end
    end

    // small index values, they decode as no operation
    task automatic fill_inst();
        for (int i = 0; i < 1024; i++) begin
            inst_mem[i] = word_t'(i);
        end
    endtask

    task automatic write_inst(input int idx, input inst_t word);
        inst_mem[idx] = word;
    endtask

    function automatic word_t read_data(input word_t addr);
        return data_mem[addr[11:2]];
    endfunction

endmodule

/* tests/cpu_tb.sv */
`include "cpu_params.svh"

module cpu_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import cpu_pkg::*;

    logic      clk;
    logic      reset;
    logic      inst_sram_en;
    word_t     inst_sram_addr;
    word_t     inst_sram_rdata;
    logic      data_sram_en;
    wmask_t    data_sram_we;
    word_t     data_sram_addr;
    word_t     data_sram_wdata;
    word_t     data_sram_rdata;
    word_t     debug_wb_pc;
    wmask_t    debug_wb_rf_we;
    reg_addr_t debug_wb_rf_wnum;
    word_t     debug_wb_rf_wdata;

    inst_t     prog [$];
    word_t     exp_pc [$];
    reg_addr_t exp_reg [$];
    word_t     exp_val [$];
    word_t     got_pc [$];
    reg_addr_t got_reg [$];
    word_t     got_val [$];
    word_t     ref_rf [`NUM_REGS];      // register file as the ISA sees it
    word_t     ref_mem [word_t];
    word_t     rng_state = 32'd76;
    logic      reset_q = 1'b1;
    int        value_errors = 0;
    int        other_errors = 0;
    int        cycles = 0;
    int        limit = 50;              // grows by ten cycles per expected entry

    cpu_top uut (.*);

    sram_model mem (
        .clk(clk),
        .inst_en(inst_sram_en), .inst_addr(inst_sram_addr), .inst_rdata(inst_sram_rdata),
        .data_en(data_sram_en), .data_we(data_sram_we), .data_addr(data_sram_addr),
        .data_wdata(data_sram_wdata), .data_rdata(data_sram_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        reset_q <= reset;
        if (cycles > limit) begin
            $display("timeout: trace stopped short after %0d cycles", cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    // trace monitor sampled mid-cycle
    always @(negedge clk) begin
        if (reset_q) begin
            if (debug_wb_rf_we != '0) begin
                other_errors++;
                $display("trace write seen while reset was applied");
            end
        end else if (debug_wb_rf_we != '0) begin
            got_pc.push_back(debug_wb_pc);
            got_reg.push_back(debug_wb_rf_wnum);
            got_val.push_back(debug_wb_rf_wdata);
        end
    end

    function word_t xorshift();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic inst_t enc_reg(logic [16:0] op, reg_addr_t rd, reg_addr_t rj,
                                      reg_addr_t rk);
        return {op, rk, rj, rd};
    endfunction

    function automatic inst_t enc_si12(logic [9:0] op, reg_addr_t rd, reg_addr_t rj,
                                       logic [11:0] si12);
        return {op, si12, rj, rd};
    endfunction

    function automatic inst_t enc_lu12i(reg_addr_t rd, logic [19:0] si20);
        return {`OP_LU12I_W, si20, rd};
    endfunction

    // offsets counted in instructions
    function automatic inst_t enc_cond(logic [5:0] op, reg_addr_t rj, reg_addr_t rd, int offs);
        return {op, 16'(offs), rj, rd};
    endfunction

    function automatic inst_t enc_b(int offs);
        logic [25:0] o;
        o = 26'(offs);
        return {`OP_B, o[15:0], o[25:16]};
    endfunction

    task automatic load_const(input reg_addr_t rd, input word_t v);
        word_t hi;
        hi = v + 32'h800;               // undo the sign of the low 12 bits
        prog.push_back(enc_lu12i(rd, hi[31:12]));
        prog.push_back(enc_si12(`OP_ADDI_W, rd, rd, v[11:0]));
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("Fail %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t expected,
                             input reg_addr_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("Fail %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    // instruction set model that runs prog up to the b-to-self
    task automatic predict();
        word_t pc;
        word_t next_pc;
        word_t a;
        word_t si12;
        word_t res;
        inst_t in;
        logic  wr;
        int    idx;
        exp_pc.delete();
        exp_reg.delete();
        exp_val.delete();
        pc = `RESET_PC;
        for (int steps = 0; steps < 1000; steps++) begin
            idx = (pc - `RESET_PC) >> 2;
            if (idx >= prog.size()) begin
                other_errors++;
                $display("reference model ran off the end of the program");
                return;
            end
            in = prog[idx];
            a = ref_rf[in[9:5]];
            si12 = {{20{in[21]}}, in[21:10]};
            wr = 1'b1;
            next_pc = pc + 32'd4;
            if (in[31:15] == `OP_ADD_W) res = a + ref_rf[in[14:10]];
            else if (in[31:15] == `OP_SUB_W) res = a - ref_rf[in[14:10]];
            else if (in[31:15] == `OP_AND) res = a & ref_rf[in[14:10]];
            else if (in[31:15] == `OP_OR) res = a | ref_rf[in[14:10]];
            else if (in[31:15] == `OP_XOR) res = a ^ ref_rf[in[14:10]];
            else if (in[31:22] == `OP_ADDI_W) res = a + si12;
            else if (in[31:25] == `OP_LU12I_W) res = {in[24:5], 12'b0};
            else if (in[31:22] == `OP_LD_W) begin
                if (!ref_mem.exists(a + si12)) begin
                    other_errors++;
                    $display("program loads a word it never stored");
                end
                res = ref_mem[a + si12];
            end else begin
                wr = 1'b0;
                if (in[31:22] == `OP_ST_W) ref_mem[a + si12] = ref_rf[in[4:0]];
                else if (in[31:26] == `OP_B)
                    next_pc = pc + {{4{in[9]}}, in[9:0], in[25:10], 2'b0};
                else if ((in[31:26] == `OP_BEQ && a == ref_rf[in[4:0]]) ||
                         (in[31:26] == `OP_BNE && a != ref_rf[in[4:0]]))
                    next_pc = pc + {{14{in[25]}}, in[25:10], 2'b0};
            end
            if (wr) begin
                if (in[4:0] != '0) ref_rf[in[4:0]] = res;
                exp_pc.push_back(pc);
                exp_reg.push_back(in[4:0]);
                exp_val.push_back(res);
            end
            if (next_pc == pc) return;
            pc = next_pc;
        end
        other_errors++;
        $display("reference model never reached the final self branch");
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // program goes in while the core is held in reset
    task automatic start_program();
        predict();
        limit += 10 * exp_pc.size();
        step();
        reset = 1'b1;
        mem.fill_inst();
        foreach (prog[i]) mem.write_inst(i, prog[i]);
        repeat (2) step();
        reset = 1'b0;
        got_pc.delete();
        got_reg.delete();
        got_val.delete();
    endtask

    task automatic wait_trace();
        while (got_pc.size() < exp_pc.size()) @(negedge clk);
        repeat (5) @(negedge clk);     // room for stray extra entries
    endtask

    task automatic compare_trace(input string name);
        if (got_pc.size() != exp_pc.size()) begin
            other_errors++;
            $display("%s saw %0d trace entries instead of %0d", name, got_pc.size(),
                     exp_pc.size());
        end
        for (int i = 0; i < exp_pc.size() && i < got_pc.size(); i++) begin
            check_word($sformatf("%s[%0d] pc", name, i), exp_pc[i], got_pc[i]);
            check_reg($sformatf("%s[%0d] wnum", name, i), exp_reg[i], got_reg[i]);
            check_word($sformatf("%s[%0d] wdata", name, i), exp_val[i], got_val[i]);
        end
    endtask

    task automatic run_program(input string name);
        start_program();
        wait_trace();
        compare_trace(name);
    endtask

    task automatic test_alu();
        prog.delete();
        load_const(1, xorshift());
        load_const(2, xorshift());
        prog.push_back(enc_reg(`OP_ADD_W, 3, 1, 2));
        prog.push_back(enc_reg(`OP_SUB_W, 4, 1, 2));
        prog.push_back(enc_reg(`OP_AND, 5, 1, 2));
        prog.push_back(enc_reg(`OP_OR, 6, 1, 2));
        prog.push_back(enc_reg(`OP_XOR, 7, 1, 2));
        prog.push_back(enc_b(0));
        run_program("alu");
    endtask

    task automatic test_sext();
        prog.delete();
        prog.push_back(enc_si12(`OP_ADDI_W, 8, 0, 12'hfff));     // -1
        prog.push_back(enc_si12(`OP_ADDI_W, 9, 0, 12'h800));     // -2048
        prog.push_back(enc_lu12i(10, 20'h80000));
        prog.push_back(enc_lu12i(11, 20'hfffff));
        prog.push_back(enc_si12(`OP_ADDI_W, 12, 11, 12'hffb));   // -5
        prog.push_back(enc_b(0));
        run_program("sext");
    endtask

    task automatic test_chain();
        prog.delete();
        load_const(1, xorshift());
        prog.push_back(enc_si12(`OP_ADDI_W, 13, 1, 12'd5));
        prog.push_back(enc_reg(`OP_ADD_W, 14, 13, 13));
        prog.push_back(enc_reg(`OP_SUB_W, 15, 14, 1));
        prog.push_back(enc_reg(`OP_XOR, 16, 15, 14));
        prog.push_back(enc_si12(`OP_ADDI_W, 17, 16, 12'hf9c)); // -100
        prog.push_back(enc_b(0));
        run_program("chain");
    endtask

    task automatic test_mem();
        word_t v;
        word_t w;
        v = xorshift();
        w = xorshift();
        prog.delete();
        load_const(18, v);
        load_const(21, w);
        prog.push_back(enc_si12(`OP_ADDI_W, 19, 0, 12'h100));
        prog.push_back(enc_si12(`OP_ST_W, 18, 19, 12'd8));
        prog.push_back(enc_si12(`OP_LD_W, 20, 19, 12'd8));
        prog.push_back(enc_si12(`OP_ST_W, 21, 19, 12'hffc));    // base minus 4
        prog.push_back(enc_si12(`OP_LD_W, 22, 19, 12'hffc));
        prog.push_back(enc_reg(`OP_ADD_W, 23, 20, 22));
        prog.push_back(enc_b(0));
        run_program("mem");
        check_word("mem word at 108", v, mem.read_data(32'h108));
        check_word("mem word at 0fc", w, mem.read_data(32'h0fc));
    endtask

    task automatic test_branch();
        int loops;
        prog.delete();
        prog.push_back(enc_si12(`OP_ADDI_W, 23, 0, 12'd3));
        prog.push_back(enc_si12(`OP_ADDI_W, 24, 0, 12'd3));
        prog.push_back(enc_cond(`OP_BEQ, 23, 24, 2));           // taken so r25 is skipped
        prog.push_back(enc_si12(`OP_ADDI_W, 25, 0, 12'd111));
        prog.push_back(enc_si12(`OP_ADDI_W, 26, 0, 12'd222));
        prog.push_back(enc_cond(`OP_BNE, 23, 24, 2));           // falls through
        prog.push_back(enc_si12(`OP_ADDI_W, 27, 0, 12'd333));
        prog.push_back(enc_si12(`OP_ADDI_W, 28, 0, 12'd0));
        prog.push_back(enc_si12(`OP_ADDI_W, 29, 0, 12'd5));
        prog.push_back(enc_si12(`OP_ADDI_W, 28, 28, 12'd1));    // loop head
        prog.push_back(enc_cond(`OP_BNE, 28, 29, 2));
        prog.push_back(enc_b(2));                               // exit
        prog.push_back(enc_b(-3));
        prog.push_back(enc_si12(`OP_ADDI_W, 30, 0, 12'd7));
        prog.push_back(enc_b(0));
        run_program("branch");
        loops = 0;
        foreach (got_reg[i]) begin
            if (got_reg[i] == 5'd28) loops++;
        end
        if (loops != 6) begin                                   // clear plus five passes
            other_errors++;
            $display("branch loop wrote its counter %0d times instead of 6", loops);
        end
    endtask

    task automatic test_reset_mid();
        prog.delete();
        load_const(1, xorshift());
        prog.push_back(enc_si12(`OP_ADDI_W, 2, 0, 12'd21));
        prog.push_back(enc_lu12i(3, 20'h5a5a5));
        prog.push_back(enc_si12(`OP_ADDI_W, 4, 0, 12'h9ab));
        prog.push_back(enc_reg(`OP_ADD_W, 5, 1, 1));
        prog.push_back(enc_reg(`OP_SUB_W, 6, 4, 2));
        prog.push_back(enc_b(0));
        start_program();
        while (got_pc.size() < 2) @(negedge clk);   // reset lands with writers in ex, mem, wb
        limit += 10 * exp_pc.size();
        step();
        reset = 1'b1;
        repeat (2) step();
        reset = 1'b0;
        got_pc.delete();
        got_reg.delete();
        got_val.delete();
        wait_trace();
        if (got_pc.size() > 0) check_word("reset_mid first pc", `RESET_PC, got_pc[0]);
        compare_trace("reset_mid");
    endtask

    initial begin
        reset = 1'b1;
        ref_rf[0] = '0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        test_alu();
        test_sext();
        test_chain();
        test_mem();
        test_branch();
        test_reset_mid();
        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+include
logic/cpu_pkg.sv
logic/pipe_buses.sv
logic/stage_fetch.sv
logic/stage_decode.sv
logic/regfile.sv
logic/stage_execute.sv
logic/stage_mem_wb.sv
logic/cpu_top.sv
tests/sram_model.sv
tests/cpu_tb.sv
